// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              progWrite,
   input  logic [mipsPkg::imemAddrWidth-1:0] progAddr,
   input  logic [31:0]                       progData,
   output logic                              wbValid,
   output logic [mipsPkg::regAddrWidth-1:0]  wbReg,
   output logic [31:0]                       wbData
);
   import mipsPkg::*;

   //////////////////////////////
   // Fetch and decode
   //////////////////////////////
   logic [31:0]             instrD;
   logic [31:0]             pcPlus4D;
   logic                    branchD;
   logic                    branchTaken;
   logic [31:0]             branchTarget;
   logic [regAddrWidth-1:0] rsD;
   logic [regAddrWidth-1:0] rtD;

   //////////////////////////////
   // Execute
   //////////////////////////////
   logic [regAddrWidth-1:0] rsE;
   logic [regAddrWidth-1:0] rtE;
   logic [regAddrWidth-1:0] rdE;
   logic                    regWriteE;
   logic                    memToRegE;
   logic                    memWriteE;
   logic                    aluSrcE;
   logic                    regDstE;
   aluOpT                   aluOpE;
   logic [31:0]             rd1E;
   logic [31:0]             rd2E;
   logic [31:0]             immE;
   logic [regAddrWidth-1:0] writeRegE;

   //////////////////////////////
   // Memory and writeback
   //////////////////////////////
   logic [31:0]             aluOutM;
   logic [31:0]             writeDataM;
   logic [regAddrWidth-1:0] writeRegM;
   logic                    regWriteM;
   logic                    memToRegM;
   logic                    memWriteM;
   logic [31:0]             resultW;
   logic [regAddrWidth-1:0] writeRegW;
   logic                    regWriteW;

   // Hazard control
   logic                    stallF;
   logic                    stallD;
   logic                    flushE;
   logic                    forwardAD;
   logic                    forwardBD;
   forwardSelT              forwardAE;
   forwardSelT              forwardBE;

   fetchStage   i_fetch  (.*);
   decodeStage  i_decode (.*);
   executeStage i_exec   (.*);
   memoryStage  i_mem    (.*);
   hazardUnit   i_hazard (.*);

endmodule

`default_nettype wire

// File: cpu_props.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_props (
   input logic                             clk,
   input logic                             reset,
   input logic                             wbValid,
   input logic                             regWriteM,
   input logic [mipsPkg::regAddrWidth-1:0] writeRegM,
   input logic                             flushE,
   input logic                             memToRegE,
   input logic                             branchD
);

   // Quiet retirement port once reset has been seen
   noWbInReset: assert property (@(posedge clk) reset && $past(reset) |-> !wbValid)
      else $error("writeback reported during reset");

   // A register 0 write leaving memory never reaches the port
   noWbToZero: assert property (@(posedge clk) disable iff (reset)
      regWriteM && writeRegM == '0 |=> !wbValid)
      else $error("writeback to register 0 reported");

   // Bubbles come only from a load in execute or a branch in decode
   flushHasCause: assert property (@(posedge clk) disable iff (reset)
      flushE |-> (memToRegE || branchD))
      else $error("execute flush without a load in execute or a branch in decode");

endmodule

bind cpu cpu_props i_props (
   .clk      (clk),
   .reset    (reset),
   .wbValid  (wbValid),
   .regWriteM(regWriteM),
   .writeRegM(writeRegM),
   .flushE   (flushE),
   .memToRegE(memToRegE),
   .branchD  (branchD)
);

`default_nettype wire

// File: cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
   import mipsPkg::*;

   localparam int programWords = 47;
   localparam int timeoutCycles = 400;
   localparam int randomTests = 10;

   logic                     clk;
   logic                     reset;
   logic                     progWrite;
   logic [imemAddrWidth-1:0] progAddr;
   logic [31:0]              progData;
   logic                     wbValid;
   logic [regAddrWidth-1:0]  wbReg;
   logic [31:0]              wbData;

   logic [31:0]             prog [imemDepth];
   logic [31:0]             lfsrState;
   logic [regAddrWidth-1:0] expReg [$];
   logic [31:0]             expData [$];
   int                      gotCount;
   int                      testErrors;
   int                      passCount;
   int                      failCount;

   cpu i_dut (
      .clk      (clk),
      .reset    (reset),
      .progWrite(progWrite),
      .progAddr (progAddr),
      .progData (progData),
      .wbValid  (wbValid),
      .wbReg    (wbReg),
      .wbData   (wbData)
   );

   always #4 clk = ~clk;

   // Galois LFSR stepped once per bit
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < n; i++) begin
         value = {value[30:0], lfsrState[0]};
         lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hA300_0000) : (lfsrState >> 1);
      end
      return value;
   endfunction

   function automatic int pickReg();
      return 1 + int'(randBits(3) % 7);
   endfunction

   function automatic logic [31:0] rType(input functT fn, input int rd, input int rs,
                                         input int rt);
      return {opRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
   endfunction

   function automatic logic [31:0] iType(input opcodeT op, input int rt, input int rs,
                                         input int imm);
      return {op, 5'(rs), 5'(rt), 16'(imm)};
   endfunction

   //////////////////////////////
   // Programs
   //////////////////////////////
   task automatic clearProgram();
      for (int i = 0; i < imemDepth; i++) begin
         prog[i] = '0;
      end
      // Last word spins on itself so the run goes quiet
      prog[imemDepth-1] = iType(opBeq, 0, 0, -1);
   endtask

   task automatic buildDirected();
      clearProgram();
      prog[0]  = iType(opAddi, 1, 0, 32767);
      prog[1]  = iType(opAddi, 2, 0, -1);
      prog[2]  = rType(fnAdd, 3, 2, 2);
      prog[3]  = rType(fnSub, 4, 3, 1);
      prog[4]  = rType(fnSlt, 5, 2, 1);
      prog[5]  = rType(fnSlt, 6, 1, 2);
      prog[6]  = rType(fnAnd, 7, 4, 3);
      prog[7]  = rType(fnOr, 6, 7, 5);
      prog[8]  = iType(opSw, 6, 0, 8);
      prog[9]  = iType(opLw, 1, 0, 8);
      prog[10] = rType(fnAdd, 2, 1, 1);
      prog[11] = iType(opLw, 3, 0, 8);
      // Taken on a just-loaded operand and skips the addi
      prog[12] = iType(opBeq, 6, 3, 1);
      prog[13] = iType(opAddi, 4, 0, 99);
      prog[14] = rType(fnAdd, 0, 5, 5);
      prog[15] = rType(fnAdd, 5, 0, 7);
      prog[16] = iType(opBeq, 0, 5, 2);
      prog[17] = rType(fnSub, 4, 2, 5);
      prog[18] = iType(opBeq, 2, 1, 1);
      prog[19] = iType(opAddi, 7, 4, -5);
      prog[20] = iType(opLw, 1, 0, 8);
      // Not taken on a just-loaded operand
      prog[21] = iType(opBeq, 0, 1, 1);
      prog[22] = iType(opAddi, 2, 1, 1);
   endtask

   task automatic buildRandom();
      int kind;
      int rd;
      int rs;
      int rt;
      clearProgram();
      for (int r = 1; r < 7; r++) begin
         prog[r-1] = iType(opAddi, r, 0, int'(randBits(16)));
      end
      // Base register for loads and stores
      prog[6] = iType(opAddi, 7, 0, 0);
      for (int i = 7; i < programWords; i++) begin
         kind = int'(randBits(3));
         rd   = pickReg();
         rs   = pickReg();
         rt   = pickReg();
         case (kind)
            0: prog[i] = rType(fnAdd, rd, rs, rt);
            1: prog[i] = rType(fnSub, rd, rs, rt);
            2: prog[i] = rType(fnAnd, rd, rs, rt);
            3: prog[i] = rType(fnOr, rd, rs, rt);
            4: prog[i] = rType(fnSlt, rd, rs, rt);
            5: prog[i] = iType(opAddi, rd, rs, int'(randBits(16)));
            6: prog[i] = iType(randBits(1) ? opSw : opLw, rd, 7, int'(randBits(4)) * 4);
            default: begin
               if (randBits(1)) begin
                  rt = rs;
               end
               prog[i] = iType(opBeq, rt, rs, 1 + int'(randBits(2) % 3));
            end
         endcase
      end
   endtask

   //////////////////////////////
   // Reference model
   //////////////////////////////
   task automatic runModel();
      logic [31:0] regs [32];
      logic [31:0] mem [dmemDepth];
      logic [31:0] pc;
      logic [31:0] nextPc;
      logic [31:0] instr;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] addr;
      logic [31:0] val;
      logic [4:0]  dest;
      logic        wr;
      int          steps;
      regs = '{default: '0};
      mem = '{default: '0};
      expReg.delete();
      expData.delete();
      pc = '0;
      steps = 0;
      while (pc[imemAddrWidth+1:2] != imemAddrWidth'(imemDepth - 1) && steps < 200) begin
         instr  = prog[pc[imemAddrWidth+1:2]];
         a      = regs[instr[25:21]];
         b      = regs[instr[20:16]];
         imm    = {{16{instr[15]}}, instr[15:0]};
         addr   = a + imm;
         nextPc = pc + 32'd4;
         dest   = instr[20:16];
         wr     = 1'b0;
         val    = '0;
         case (instr[31:26])
            opRType: begin
               dest = instr[15:11];
               wr   = 1'b1;
               case (instr[5:0])
                  fnAdd:   val = a + b;
                  fnSub:   val = a - b;
                  fnAnd:   val = a & b;
                  fnOr:    val = a | b;
                  fnSlt:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: wr = 1'b0;
               endcase
            end
            opAddi: begin
               wr  = 1'b1;
               val = addr;
            end
            opLw: begin
               wr  = 1'b1;
               val = mem[addr[dmemAddrWidth+1:2]];
            end
            opSw:    mem[addr[dmemAddrWidth+1:2]] = b;
            opBeq:   nextPc = (a == b) ? nextPc + (imm << 2) : nextPc;
            default: ;
         endcase
         if (wr && dest != 5'd0) begin
            regs[dest] = val;
            expReg.push_back(dest);
            expData.push_back(val);
         end
         pc = nextPc;
         steps++;
      end
   endtask

   // Retirement monitor sampled mid-cycle
   always @(negedge clk) begin
      if (!reset && wbValid) begin
         assert (gotCount < expReg.size()) else begin
            $display("ERROR: unexpected writeback r%0d=%h after all %0d expected ones",
                     wbReg, wbData, expReg.size());
            testErrors++;
         end
         if (gotCount < expReg.size()) begin
            assert (wbReg == expReg[gotCount] && wbData == expData[gotCount]) else begin
               $display("MISMATCH at %0t: writeback %0d got r%0d=%h, expected r%0d=%h",
                        $time, gotCount, wbReg, wbData, expReg[gotCount],
                        expData[gotCount]);
               testErrors++;
            end
         end
         gotCount++;
      end
   end

   //////////////////////////////
   // Test sequencing
   //////////////////////////////
   task automatic runTest(input int num, input string name);
      int cycles;
      runModel();
      @(posedge clk);
      reset <= 1'b1;
      for (int i = 0; i < imemDepth; i++) begin
         @(posedge clk);
         progWrite <= 1'b1;
         progAddr  <= imemAddrWidth'(i);
         progData  <= prog[i];
      end
      @(posedge clk);
      progWrite <= 1'b0;
      gotCount   = 0;
      testErrors = 0;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      cycles = 0;
      while (gotCount < expReg.size() && cycles < timeoutCycles) begin
         @(posedge clk);
         cycles++;
      end
      assert (gotCount >= expReg.size()) else begin
         $display("ERROR: timeout in test %0d, only %0d of %0d writebacks seen", num,
                  gotCount, expReg.size());
         testErrors++;
      end
      // Quiet period to catch extra retirements
      cycles = 0;
      while (cycles < 16) begin
         @(posedge clk);
         cycles++;
      end
      if (testErrors == 0) begin
         passCount++;
      end else begin
         failCount++;
      end
      $display("test %0d %s: %s, %0d writebacks", num, name,
               (testErrors == 0) ? "ok" : "failed", gotCount);
   endtask

   initial begin
      clk       = 1'b0;
      reset     = 1'b1;
      progWrite = 1'b0;
      progAddr  = '0;
      progData  = '0;
      lfsrState = 32'hb3c4_8af8;
      gotCount  = 0;
      passCount = 0;
      failCount = 0;
      buildDirected();
      runTest(0, "directed");
      for (int t = 1; t <= randomTests; t++) begin
         buildRandom();
         runTest(t, "random");
      end
      $display("tests passed: %0d, failed: %0d", passCount, failCount);
      if (failCount == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
   input  logic                             clk,
   input  logic                             reset,
   input  logic [31:0]                      instrD,
   input  logic [31:0]                      pcPlus4D,
   input  logic                             forwardAD,
   input  logic                             forwardBD,
   input  logic [31:0]                      aluOutM,
   input  logic                             flushE,
   input  logic [mipsPkg::regAddrWidth-1:0] writeRegW,
   input  logic [31:0]                      resultW,
   input  logic                             regWriteW,
   output logic                             branchD,
   output logic                             branchTaken,
   output logic [31:0]                      branchTarget,
   output logic [mipsPkg::regAddrWidth-1:0] rsD,
   output logic [mipsPkg::regAddrWidth-1:0] rtD,
   output logic [mipsPkg::regAddrWidth-1:0] rsE,
   output logic [mipsPkg::regAddrWidth-1:0] rtE,
   output logic                             regWriteE,
   output logic                             memToRegE,
   output logic                             memWriteE,
   output logic                             aluSrcE,
   output logic                             regDstE,
   output mipsPkg::aluOpT                   aluOpE,
   output logic [31:0]                      rd1E,
   output logic [31:0]                      rd2E,
   output logic [31:0]                      immE,
   output logic [mipsPkg::regAddrWidth-1:0] rdE
);
   import mipsPkg::*;

   opcodeT                  opcode;
   functT                   funct;
   logic [regAddrWidth-1:0] rdD;
   logic                    regWriteD;
   logic                    memToRegD;
   logic                    memWriteD;
   logic                    aluSrcD;
   logic                    regDstD;
   aluOpT                   aluOpD;
   logic [31:0]             regFile [regCount];
   logic [31:0]             rd1D;
   logic [31:0]             rd2D;
   logic [31:0]             immD;
   logic [31:0]             eqA;
   logic [31:0]             eqB;
   logic                    wbHit;

   assign opcode = opcodeT'(instrD[31:26]);
   assign funct  = functT'(instrD[5:0]);
   assign rsD    = instrD[25:21];
   assign rtD    = instrD[20:16];
   assign rdD    = instrD[15:11];
   assign immD   = {{16{instrD[15]}}, instrD[15:0]};

   //////////////////////////////
   // Control decode
   //////////////////////////////
   always_comb begin
      regWriteD = 1'b0;
      memToRegD = 1'b0;
      memWriteD = 1'b0;
      aluSrcD   = 1'b0;
      regDstD   = 1'b0;
      branchD   = 1'b0;
      aluOpD    = aluAdd;
      case (opcode)
         opRType: begin
            regDstD   = 1'b1;
            regWriteD = 1'b1;
            case (funct)
               fnAdd:   aluOpD = aluAdd;
               fnSub:   aluOpD = aluSub;
               fnAnd:   aluOpD = aluAnd;
               fnOr:    aluOpD = aluOr;
               fnSlt:   aluOpD = aluSlt;
               // Nop and unknown functs write nothing
               default: regWriteD = 1'b0;
            endcase
         end
         opAddi: begin
            regWriteD = 1'b1;
            aluSrcD   = 1'b1;
         end
         opLw: begin
            regWriteD = 1'b1;
            memToRegD = 1'b1;
            aluSrcD   = 1'b1;
         end
         opSw: begin
            memWriteD = 1'b1;
            aluSrcD   = 1'b1;
         end
         opBeq:   branchD = 1'b1;
         default: ;
      endcase
   end

   // Register file, register 0 is never written
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < regCount; i++) begin
            regFile[i] <= '0;
         end
      end else if (regWriteW && writeRegW != '0) begin
         regFile[writeRegW] <= resultW;
      end
   end

   // Writeback in this same cycle goes straight to the readers
   assign wbHit = regWriteW && (writeRegW != '0);
   assign rd1D  = (wbHit && writeRegW == rsD) ? resultW : regFile[rsD];
   assign rd2D  = (wbHit && writeRegW == rtD) ? resultW : regFile[rtD];

   // Early branch resolution
   assign eqA          = forwardAD ? aluOutM : rd1D;
   assign eqB          = forwardBD ? aluOutM : rd2D;
   assign branchTaken  = branchD && (eqA == eqB);
   assign branchTarget = pcPlus4D + {immD[29:0], 2'b00};

   //////////////////////////////
   // Decode/execute register
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset || flushE) begin
         regWriteE <= 1'b0;
         memToRegE <= 1'b0;
         memWriteE <= 1'b0;
         aluSrcE   <= 1'b0;
         regDstE   <= 1'b0;
         aluOpE    <= aluAdd;
         rsE       <= '0;
         rtE       <= '0;
         rdE       <= '0;
      end else begin
         regWriteE <= regWriteD;
         memToRegE <= memToRegD;
         memWriteE <= memWriteD;
         aluSrcE   <= aluSrcD;
         regDstE   <= regDstD;
         aluOpE    <= aluOpD;
         rsE       <= rsD;
         rtE       <= rtD;
         rdE       <= rdD;
      end
   end

   // Operand data
   always_ff @(posedge clk) begin
      rd1E <= rd1D;
      rd2E <= rd2D;
      immE <= immD;
   end

endmodule

`default_nettype wire

// File: executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             regWriteE,
   input  logic                             memToRegE,
   input  logic                             memWriteE,
   input  logic                             aluSrcE,
   input  logic                             regDstE,
   input  mipsPkg::aluOpT                   aluOpE,
   input  logic [31:0]                      rd1E,
   input  logic [31:0]                      rd2E,
   input  logic [31:0]                      immE,
   input  logic [mipsPkg::regAddrWidth-1:0] rtE,
   input  logic [mipsPkg::regAddrWidth-1:0] rdE,
   input  mipsPkg::forwardSelT              forwardAE,
   input  mipsPkg::forwardSelT              forwardBE,
   input  logic [31:0]                      resultW,
   output logic [mipsPkg::regAddrWidth-1:0] writeRegE,
   output logic [31:0]                      aluOutM,
   output logic [31:0]                      writeDataM,
   output logic [mipsPkg::regAddrWidth-1:0] writeRegM,
   output logic                             regWriteM,
   output logic                             memToRegM,
   output logic                             memWriteM
);
   import mipsPkg::*;

   logic [31:0] srcA;
   logic [31:0] srcB;
   logic [31:0] writeDataE;
   logic [31:0] aluOutE;

   function automatic logic [31:0] pickOperand(
      input forwardSelT  sel,
      input logic [31:0] regVal,
      input logic [31:0] wbVal,
      input logic [31:0] memVal
   );
      case (sel)
         fwdResultW: return wbVal;
         fwdAluOutM: return memVal;
         default:    return regVal;
      endcase
   endfunction

   assign srcA       = pickOperand(forwardAE, rd1E, resultW, aluOutM);
   assign writeDataE = pickOperand(forwardBE, rd2E, resultW, aluOutM);
   assign srcB       = aluSrcE ? immE : writeDataE;
   assign writeRegE  = regDstE ? rdE : rtE;

   // ALU, add and sub wrap
   always_comb begin
      case (aluOpE)
         aluSub:  aluOutE = srcA - srcB;
         aluAnd:  aluOutE = srcA & srcB;
         aluOr:   aluOutE = srcA | srcB;
         aluSlt:  aluOutE = {31'd0, $signed(srcA) < $signed(srcB)};
         default: aluOutE = srcA + srcB;
      endcase
   end

   //////////////////////////////
   // Execute/memory register
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         regWriteM <= 1'b0;
         memToRegM <= 1'b0;
         memWriteM <= 1'b0;
      end else begin
         regWriteM <= regWriteE;
         memToRegM <= memToRegE;
         memWriteM <= memWriteE;
      end
   end

   always_ff @(posedge clk) begin
      aluOutM    <= aluOutE;
      writeDataM <= writeDataE;
      writeRegM  <= writeRegE;
   end

endmodule

`default_nettype wire

// File: fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              progWrite,
   input  logic [mipsPkg::imemAddrWidth-1:0] progAddr,
   input  logic [31:0]                       progData,
   input  logic                              stallF,
   input  logic                              stallD,
   input  logic                              branchTaken,
   input  logic [31:0]                       branchTarget,
   output logic [31:0]                       instrD,
   output logic [31:0]                       pcPlus4D
);
   import mipsPkg::*;

   logic [31:0] imem [imemDepth];
   logic [31:0] pcF;
   logic [31:0] pcPlus4F;
   logic [31:0] instrF;

   // Program load port, open only while reset is held
   always_ff @(posedge clk) begin
      if (reset && progWrite) begin
         imem[progAddr] <= progData;
      end
   end

   assign instrF   = imem[pcF[imemAddrWidth+1:2]];
   assign pcPlus4F = pcF + 32'd4;

   always_ff @(posedge clk) begin
      if (reset) begin
         pcF <= '0;
      end else if (!stallF) begin
         pcF <= branchTaken ? branchTarget : pcPlus4F;
      end
   end

   //////////////////////////////
   // Fetch/decode register
   //////////////////////////////
   // Stall wins over squash so a beq waiting on its operands stays put
   always_ff @(posedge clk) begin
      if (reset) begin
         instrD   <= '0;
         pcPlus4D <= '0;
      end else if (!stallD) begin
         instrD   <= branchTaken ? 32'd0 : instrF;
         pcPlus4D <= pcPlus4F;
      end
   end

endmodule

`default_nettype wire

// File: hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
   input  logic                             clk,
   input  logic [mipsPkg::regAddrWidth-1:0] rsD,
   input  logic [mipsPkg::regAddrWidth-1:0] rtD,
   input  logic [mipsPkg::regAddrWidth-1:0] rsE,
   input  logic [mipsPkg::regAddrWidth-1:0] rtE,
   input  logic                             branchD,
   input  logic [mipsPkg::regAddrWidth-1:0] writeRegE,
   input  logic [mipsPkg::regAddrWidth-1:0] writeRegM,
   input  logic [mipsPkg::regAddrWidth-1:0] writeRegW,
   input  logic                             regWriteE,
   input  logic                             regWriteM,
   input  logic                             regWriteW,
   input  logic                             memToRegE,
   input  logic                             memToRegM,
   output logic                             stallF,
   output logic                             stallD,
   output logic                             flushE,
   output logic                             forwardAD,
   output logic                             forwardBD,
   output mipsPkg::forwardSelT              forwardAE,
   output mipsPkg::forwardSelT              forwardBE
);
   import mipsPkg::*;

   logic lwStall;
   logic branchStall;
   logic memHitD;
   logic exHitD;

   // Memory stage has priority, it holds the newer value
   function automatic forwardSelT selectSource(input logic [regAddrWidth-1:0] src);
      if (src != '0 && regWriteM && src == writeRegM) begin
         return fwdAluOutM;
      end
      if (src != '0 && regWriteW && src == writeRegW) begin
         return fwdResultW;
      end
      return fwdRegFile;
   endfunction

   always_comb begin
      forwardAE = selectSource(rsE);
      forwardBE = selectSource(rtE);
   end

   // Branch compare taps the memory-stage ALU result
   assign forwardAD = (rsD != '0) && regWriteM && (rsD == writeRegM);
   assign forwardBD = (rtD != '0) && regWriteM && (rtD == writeRegM);

   assign exHitD  = regWriteE && (writeRegE == rsD || writeRegE == rtD);
   assign memHitD = memToRegM && (writeRegM == rsD || writeRegM == rtD);

   assign lwStall     = memToRegE && (rtE == rsD || rtE == rtD);
   assign branchStall = branchD && (exHitD || memHitD);

   assign stallF = lwStall || branchStall;
   assign stallD = lwStall || branchStall;
   assign flushE = lwStall || branchStall;

endmodule

`default_nettype wire

// File: memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
   input  logic                             clk,
   input  logic                             reset,
   input  logic [31:0]                      aluOutM,
   input  logic [31:0]                      writeDataM,
   input  logic [mipsPkg::regAddrWidth-1:0] writeRegM,
   input  logic                             regWriteM,
   input  logic                             memToRegM,
   input  logic                             memWriteM,
   output logic [31:0]                      resultW,
   output logic [mipsPkg::regAddrWidth-1:0] writeRegW,
   output logic                             regWriteW,
   output logic                             wbValid,
   output logic [mipsPkg::regAddrWidth-1:0] wbReg,
   output logic [31:0]                      wbData
);
   import mipsPkg::*;

   logic [31:0]              dmem [dmemDepth];
   logic [dmemAddrWidth-1:0] dAddr;
   logic [31:0]              readDataM;
   logic [31:0]              readDataW;
   logic [31:0]              aluOutW;
   logic                     memToRegW;

   // Word index from byte address
   assign dAddr = aluOutM[dmemAddrWidth+1:2];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < dmemDepth; i++) begin
            dmem[i] <= '0;
         end
      end else if (memWriteM) begin
         dmem[dAddr] <= writeDataM;
      end
   end

   assign readDataM = dmem[dAddr];

   //////////////////////////////
   // Memory/writeback register
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         regWriteW <= 1'b0;
         memToRegW <= 1'b0;
      end else begin
         regWriteW <= regWriteM;
         memToRegW <= memToRegM;
      end
   end

   always_ff @(posedge clk) begin
      readDataW <= readDataM;
      aluOutW   <= aluOutM;
      writeRegW <= writeRegM;
   end

   assign resultW = memToRegW ? readDataW : aluOutW;

   // Retirement port, writes to register 0 stay hidden
   assign wbValid = regWriteW && (writeRegW != '0);
   assign wbReg   = writeRegW;
   assign wbData  = resultW;

endmodule

`default_nettype wire

// File: mipsPkg.sv
`default_nettype none

package mipsPkg;

   // Storage sizes
   localparam int regAddrWidth  = 5;
   localparam int regCount      = 2 ** regAddrWidth;
   localparam int imemDepth     = 64;
   localparam int imemAddrWidth = $clog2(imemDepth);
   localparam int dmemDepth     = 64;
   localparam int dmemAddrWidth = $clog2(dmemDepth);

   // Primary opcode field, instr[31:26]
   typedef enum logic [5:0] {
      opRType = 6'h00,
      opBeq   = 6'h04,
      opAddi  = 6'h08,
      opLw    = 6'h23,
      opSw    = 6'h2b
   } opcodeT;

   // R-type function field, instr[5:0]
   typedef enum logic [5:0] {
      fnAdd = 6'h20,
      fnSub = 6'h22,
      fnAnd = 6'h24,
      fnOr  = 6'h25,
      fnSlt = 6'h2a
   } functT;

   typedef enum logic [2:0] {
      aluAdd = 3'd0,
      aluSub = 3'd1,
      aluAnd = 3'd2,
      aluOr  = 3'd3,
      aluSlt = 3'd4
   } aluOpT;

   // Operand source for the execute stage
   typedef enum logic [1:0] {
      fwdRegFile = 2'b00,
      fwdResultW = 2'b01,
      fwdAluOutM = 2'b10
   } forwardSelT;

endpackage

`default_nettype wire

// File: sim.f
mipsPkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
hazardUnit.sv
cpu.sv
cpu_props.sv
cpu_tb.sv
